//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= mem_check_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- error_log.sv
`timescale 1ns/100ps

module error_log (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  error,
    input  logic                  loop_complete,
    input  test_pkg::err_report_t report,
    output logic [15:0]           error_count,
    output logic [15:0]           loop_count,
    output test_pkg::err_report_t first_report,
    output logic                  first_valid
);
    import test_pkg::*;

    localparam logic [15:0] COUNT_MAX = 16'hffff;

    logic take_first;

    assign take_first = error && !first_valid;

    // Both counters stick at their maximum.
    always_ff @(posedge clk) begin
        if (rst) begin
            error_count <= '0;
            loop_count  <= '0;
            first_valid <= 1'b0;
        end else begin
            if (error && (error_count != COUNT_MAX)) begin
                error_count <= error_count + 16'd1;
            end
            if (loop_complete && (loop_count != COUNT_MAX)) begin
                loop_count <= loop_count + 16'd1;
            end
            if (take_first) begin
                first_valid <= 1'b1;
            end
        end
    end

    // Only the first mismatch since reset is kept.
    always_ff @(posedge clk) begin
        if (take_first) begin
            first_report <= report;
        end
    end

endmodule

//--- mem_check_checker.sv
`timescale 1ns/100ps

module mem_check_checker #(
    parameter int DEPTH = 64
) (
    input logic clk,
    input logic rst,
    input logic init_done,
    input logic loop_complete,
    input logic error
);
    int unsigned gap;
    logic        seen_loop;
    int unsigned pulse_fails = 0;
    int unsigned period_fails = 0;
    int unsigned error_fails = 0;
    int unsigned init_fails = 0;
    int unsigned fail_count;

    assign fail_count = pulse_fails + period_fails + error_fails + init_fails;

    // Cycles since the last loop_complete pulse.
    always_ff @(posedge clk) begin
        if (rst) begin
            gap       <= 0;
            seen_loop <= 1'b0;
        end else if (loop_complete) begin
            gap       <= 1;
            seen_loop <= 1'b1;
        end else begin
            gap <= gap + 1;
        end
    end

    pulse_single: assert property (@(posedge clk) disable iff (rst)
        loop_complete |=> !loop_complete)
    else begin
        pulse_fails++;
        $error("loop_complete held for more than one cycle");
    end

    // One START cycle plus one compare per address.
    loop_period: assert property (@(posedge clk) disable iff (rst)
        (loop_complete && seen_loop) |-> (gap == DEPTH + 1))
    else begin
        period_fails++;
        $error("loop_complete pulses are %0d cycles apart", gap);
    end

    no_early_error: assert property (@(posedge clk) disable iff (rst)
        !init_done |-> !error)
    else begin
        error_fails++;
        $error("error raised before init_done");
    end

    init_stays_high: assert property (@(posedge clk) disable iff (rst)
        $fell(init_done) |-> $past(rst))
    else begin
        init_fails++;
        $error("init_done fell outside reset");
    end

endmodule

//--- mem_check_tb.sv
`timescale 1ns/100ps

module mem_check_tb;
    import mem_pkg::*;
    import test_pkg::*;

    localparam int DEPTH        = 64;
    localparam int ADDRESS_STEP = 1;
    localparam int NUM_FAULTS   = 4;
    // Two loops per write, the clean loops at start and one at the end.
    localparam int NUM_LOOPS    = 7 + 4 * NUM_FAULTS;
    localparam int TIMEOUT_NS   = (DEPTH + 1) * (NUM_LOOPS + 4) * 10 + (DEPTH + 8) * 10;

    logic        clk;
    logic        rst;
    logic        wr_en;
    addr_t       wr_addr;
    data_t       wr_data;
    logic        init_done;
    logic        loop_complete;
    logic        error;
    err_report_t report;
    err_report_t first_report;
    logic        first_valid;
    logic [15:0] error_count;
    logic [15:0] loop_count;
    integer      seed = 32'he805_6a6f;
    int          checks = 0;
    int          errors = 0;

    // Expected shadow RAM contents as the tester sees them.
    data_t       ref_mem [DEPTH];
    logic        pending_we;
    addr_t       pending_addr;
    data_t       pending_data;
    logic        loop_dirty;
    logic        count_due;
    logic        skip_count;
    int          expect_delta;
    int          loops_seen;
    int          cycles_out;
    logic [15:0] base_count;
    logic        have_first;
    err_report_t first_seen;

    mem_check_top #(.DEPTH(DEPTH), .ADDRESS_STEP(ADDRESS_STEP)) UUT (
        .clk          (clk),
        .rst          (rst),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .init_done    (init_done),
        .loop_complete(loop_complete),
        .error        (error),
        .report       (report),
        .first_report (first_report),
        .first_valid  (first_valid),
        .error_count  (error_count),
        .loop_count   (loop_count)
    );

    bind rom_test mem_check_checker #(.DEPTH(DEPTH)) u_checker (
        .clk          (clk),
        .rst          (rst),
        .init_done    (init_done),
        .loop_complete(loop_complete),
        .error        (error)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERROR at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
        end
    endtask

    // Mismatching words in one full loop over the reference copy.
    function automatic int expected_errors();
        int n;
        n = 0;
        for (int a = 0; a < DEPTH; a++) begin
            if (ref_mem[a] != pattern_word(addr_t'(a))) begin
                n++;
            end
        end
        return n;
    endfunction

    // Returns 1 ns into the cycle right after a loop_complete pulse.
    task automatic wait_loop_end();
        @(negedge clk);
        while (!loop_complete) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    // The loop that takes the write is partly stale, the one after is clean.
    task automatic write_and_settle(input addr_t addr, input data_t data);
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(posedge clk);
        #1;
        wr_en = 1'b0;
        wait_loop_end();
        wait_loop_end();
    endtask

    always @(negedge clk) begin
        if (rst) begin
            for (int a = 0; a < DEPTH; a++) begin
                ref_mem[a] = pattern_word(addr_t'(a));
            end
            pending_we = 1'b0;
            loop_dirty = 1'b0;
            count_due  = 1'b0;
            skip_count = 1'b0;
            loops_seen = 0;
            cycles_out = 0;
            base_count = '0;
            have_first = 1'b0;
        end else begin
            // The loader takes one edge per word before init_done rises.
            check_value("init_done", 32'(init_done), 32'(cycles_out >= DEPTH));
            if (count_due) begin
                if (!skip_count) begin
                    check_value("errors in loop", 32'(16'(error_count - base_count)),
                                32'(expect_delta));
                end
                check_value("loop_count", 32'(loop_count), 32'(loops_seen));
                base_count = error_count;
                count_due  = 1'b0;
            end
            check_value("first_valid", 32'(first_valid), 32'(have_first));
            if (first_valid && have_first) begin
                check_value("first_report", 32'(first_report), 32'(first_seen));
            end
            if (error) begin
                check_value("report.state", 32'(report.state), 32'(STATE_VERIFY_INIT));
                check_value("report.expected", 32'(report.expected),
                            32'(pattern_word(report.address)));
                check_value("report.actual", 32'(report.actual), 32'(ref_mem[report.address]));
                if (!have_first) begin
                    have_first = 1'b1;
                    first_seen = report;
                end
            end
            if (loop_complete) begin
                loops_seen++;
                skip_count   = loop_dirty;
                expect_delta = expected_errors();
                loop_dirty   = 1'b0;
                count_due    = 1'b1;
            end
            // A write lands at the next edge, so compares see it one cycle later.
            if (pending_we) begin
                ref_mem[pending_addr] = pending_data;
            end
            pending_we   = wr_en && (cycles_out >= DEPTH);
            pending_addr = wr_addr;
            pending_data = wr_data;
            if (pending_we) begin
                loop_dirty = 1'b1;
            end
            cycles_out++;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("TIMEOUT: the run did not finish within %0d ns", TIMEOUT_NS);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        addr_t       addr;
        data_t       data;
        err_report_t first_saved;
        logic [15:0] count_before;
        addr_t       faults [$];

        rst     = 1'b1;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // Writes during the loader phase must be dropped.
        repeat (6) begin
            wr_en   = 1'b1;
            wr_addr = addr_t'($random(seed));
            wr_data = data_t'($random(seed));
            @(posedge clk);
            #1;
        end
        wr_en = 1'b0;

        wait (init_done === 1'b1);
        wait_loop_end();
        wait_loop_end();
        check_value("loop_count after two loops", 32'(loop_count), 32'd2);
        check_value("error_count after clean loops", 32'(error_count), 32'd0);

        // Single corrupted word.
        addr = addr_t'($random(seed));
        data = data_t'($random(seed));
        while (data == pattern_word(addr)) begin
            data = data_t'($random(seed));
        end
        faults.push_back(addr);
        write_and_settle(addr, data);
        check_value("first_valid after fault", 32'(first_valid), 32'd1);
        check_value("first_report.address", 32'(first_report.address), 32'(addr));
        check_value("first_report.expected", 32'(first_report.expected),
                    32'(pattern_word(addr)));
        check_value("first_report.actual", 32'(first_report.actual), 32'(data));
        first_saved = first_report;

        repeat (NUM_FAULTS) begin
            addr = addr_t'($random(seed));
            data = data_t'($random(seed));
            faults.push_back(addr);
            write_and_settle(addr, data);
        end
        check_value("first_report after more faults", 32'(first_report), 32'(first_saved));

        // Write the pattern back over every fault.
        foreach (faults[i]) begin
            write_and_settle(faults[i], pattern_word(faults[i]));
        end
        count_before = error_count;
        wait_loop_end();
        check_value("error_count after repair", 32'(error_count), 32'(count_before));
        check_value("first_report at end", 32'(first_report), 32'(first_saved));

        repeat (2) @(posedge clk);
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 UUT.u_test.u_checker.fail_count);
        if (errors == 0 && UUT.u_test.u_checker.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- mem_check_top.sv
`timescale 1ns/100ps

module mem_check_top #(
    parameter int DEPTH        = 2 ** mem_pkg::ADDR_W,
    parameter int ADDRESS_STEP = 1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_en,
    input  mem_pkg::addr_t        wr_addr,
    input  mem_pkg::data_t        wr_data,
    output logic                  init_done,
    output logic                  loop_complete,
    output logic                  error,
    output test_pkg::err_report_t report,
    output test_pkg::err_report_t first_report,
    output logic                  first_valid,
    output logic [15:0]           error_count,
    output logic [15:0]           loop_count
);
    import mem_pkg::*;

    addr_t ldr_rom_addr;
    data_t ldr_rom_data;
    logic  ldr_we;
    addr_t ldr_waddr;
    data_t ldr_wdata;
    addr_t test_ram_addr;
    data_t test_ram_data;
    addr_t test_rom_addr;
    data_t test_rom_data;
    logic  ram_we;
    addr_t ram_waddr;
    data_t ram_wdata;

    // The loader owns the RAM write port until init_done, then the
    // external port takes over. External writes before that are lost.
    always_comb begin
        if (init_done) begin
            ram_we    = wr_en;
            ram_waddr = wr_addr;
            ram_wdata = wr_data;
        end else begin
            ram_we    = ldr_we;
            ram_waddr = ldr_waddr;
            ram_wdata = ldr_wdata;
        end
    end

    pattern_rom #(.DEPTH(DEPTH)) u_rom (
        .rd_addr_a(ldr_rom_addr),
        .rd_data_a(ldr_rom_data),
        .rd_addr_b(test_rom_addr),
        .rd_data_b(test_rom_data)
    );

    shadow_ram #(.DEPTH(DEPTH)) u_ram (
        .clk  (clk),
        .we   (ram_we),
        .waddr(ram_waddr),
        .wdata(ram_wdata),
        .raddr(test_ram_addr),
        .rdata(test_ram_data)
    );

    ram_loader #(.DEPTH(DEPTH)) u_loader (
        .clk      (clk),
        .rst      (rst),
        .rom_addr (ldr_rom_addr),
        .rom_data (ldr_rom_data),
        .we       (ldr_we),
        .waddr    (ldr_waddr),
        .wdata    (ldr_wdata),
        .init_done(init_done)
    );

    rom_test #(.DEPTH(DEPTH), .ADDRESS_STEP(ADDRESS_STEP)) u_test (
        .clk             (clk),
        .rst             (rst),
        .init_done       (init_done),
        .read_address    (test_ram_addr),
        .read_data       (test_ram_data),
        .rom_read_address(test_rom_addr),
        .rom_read_data   (test_rom_data),
        .loop_complete   (loop_complete),
        .error           (error),
        .report          (report)
    );

    error_log u_log (
        .clk          (clk),
        .rst          (rst),
        .error        (error),
        .loop_complete(loop_complete),
        .report       (report),
        .error_count  (error_count),
        .loop_count   (loop_count),
        .first_report (first_report),
        .first_valid  (first_valid)
    );

endmodule

//--- mem_pkg.sv
package mem_pkg;

    // Default geometry of the checked memory.
    localparam int ADDR_W = 6;
    localparam int DATA_W = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // Constants that scramble the address into the pattern word.
    localparam logic [31:0] PATTERN_MULT = 32'h0000_009d;
    localparam logic [31:0] PATTERN_SEED = 32'h5a3c_c3a5;

    // Known contents of the working memory at a given address.
    // Neighbouring addresses get very different words, so a stuck
    // or swapped address line shows up as a mismatch.
    function automatic data_t pattern_word(input addr_t addr);
        logic [31:0] mix;
        mix = 32'(addr) * PATTERN_MULT;
        mix = mix ^ PATTERN_SEED;
        mix = mix ^ (mix >> 13);
        mix = mix ^ (mix >> 7);
        return data_t'(mix);
    endfunction

endpackage

//--- pattern_rom.sv
`timescale 1ns/100ps

module pattern_rom #(
    parameter int DEPTH = 64
) (
    input  mem_pkg::addr_t rd_addr_a,
    output mem_pkg::data_t rd_data_a,
    input  mem_pkg::addr_t rd_addr_b,
    output mem_pkg::data_t rd_data_b
);
    import mem_pkg::*;

    data_t rom [DEPTH];

    // Contents are fixed at elaboration from the pattern function.
    for (genvar i = 0; i < DEPTH; i++) begin : g_word
        assign rom[i] = pattern_word(addr_t'(i));
    end

    // Port A feeds the loader, port B the tester.
    assign rd_data_a = rom[rd_addr_a];
    assign rd_data_b = rom[rd_addr_b];

endmodule

//--- ram_loader.sv
`timescale 1ns/100ps

module ram_loader #(
    parameter int DEPTH = 64
) (
    input  logic           clk,
    input  logic           rst,
    output mem_pkg::addr_t rom_addr,
    input  mem_pkg::data_t rom_data,
    output logic           we,
    output mem_pkg::addr_t waddr,
    output mem_pkg::data_t wdata,
    output logic           init_done
);
    import mem_pkg::*;

    localparam addr_t LAST_ADDR = addr_t'(DEPTH - 1);

    addr_t count;

    // One word per cycle, starting at address 0 right after reset.
    // init_done rises on the edge after the last write and holds.
    always_ff @(posedge clk) begin
        if (rst) begin
            count     <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            if (count == LAST_ADDR) begin
                init_done <= 1'b1;
            end else begin
                count <= count + addr_t'(1);
            end
        end
    end

    // ROM port A and the RAM write port share the same address.
    assign rom_addr = count;
    assign waddr    = count;
    assign wdata    = rom_data;
    assign we       = ~init_done;

endmodule

//--- rom_test.sv
`timescale 1ns/100ps

module rom_test #(
    parameter int DEPTH        = 64,
    parameter int ADDRESS_STEP = 1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  init_done,
    output mem_pkg::addr_t        read_address,
    input  mem_pkg::data_t        read_data,
    output mem_pkg::addr_t        rom_read_address,
    input  mem_pkg::data_t        rom_read_data,
    output logic                  loop_complete,
    output logic                  error,
    output test_pkg::err_report_t report
);
    import mem_pkg::*;
    import test_pkg::*;

    // Last address actually compared in a loop.
    localparam int    LAST_INT  = ((DEPTH / ADDRESS_STEP) - 1) * ADDRESS_STEP;
    localparam addr_t LAST_ADDR = addr_t'(LAST_INT);
    localparam addr_t STEP      = addr_t'(ADDRESS_STEP);

    state_t state;
    logic   mismatch;

    assign mismatch = (state == STATE_VERIFY_INIT) && (rom_read_data != read_data);

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= STATE_START;
            read_address     <= '0;
            rom_read_address <= '0;
            loop_complete    <= 1'b0;
            error            <= 1'b0;
        end else begin
            case (state)
                STATE_START: begin
                    // Held here until the shadow RAM has been loaded.
                    loop_complete    <= 1'b0;
                    error            <= 1'b0;
                    read_address     <= '0;
                    rom_read_address <= '0;
                    if (init_done) begin
                        state <= STATE_VERIFY_INIT;
                    end
                end
                STATE_VERIFY_INIT: begin
                    error <= mismatch;
                    if (read_address != LAST_ADDR) begin
                        read_address     <= read_address + STEP;
                        rom_read_address <= rom_read_address + STEP;
                    end else begin
                        read_address     <= '0;
                        rom_read_address <= '0;
                        loop_complete    <= 1'b1;
                        state            <= STATE_START;
                    end
                end
                default: begin
                    state <= STATE_START;
                end
            endcase
        end
    end

    // Report keeps the last mismatch until the next one.
    always_ff @(posedge clk) begin
        if (mismatch) begin
            report.state    <= state;
            report.address  <= read_address;
            report.expected <= rom_read_data;
            report.actual   <= read_data;
        end
    end

endmodule

//--- shadow_ram.sv
`timescale 1ns/100ps

module shadow_ram #(
    parameter int DEPTH = 64
) (
    input  logic           clk,
    input  logic           we,
    input  mem_pkg::addr_t waddr,
    input  mem_pkg::data_t wdata,
    input  mem_pkg::addr_t raddr,
    output mem_pkg::data_t rdata
);
    import mem_pkg::*;

    data_t mem [DEPTH];

    // Write port, shared between the loader and the external port.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read is combinational so a word written at an edge is seen
    // by the tester on the following cycle.
    assign rdata = mem[raddr];

endmodule

//--- tb.f
mem_pkg.sv
test_pkg.sv
pattern_rom.sv
shadow_ram.sv
ram_loader.sv
rom_test.sv
error_log.sv
mem_check_top.sv
mem_check_checker.sv
mem_check_tb.sv

//--- test_pkg.sv
package test_pkg;

    // Tester FSM state codes, kept 8 bits wide since they are reported.
    typedef logic [7:0] state_t;

    localparam state_t STATE_START       = 8'd1;
    localparam state_t STATE_VERIFY_INIT = 8'd2;

    // One mismatch as seen by the tester.
    typedef struct packed {
        state_t         state;
        mem_pkg::addr_t address;
        mem_pkg::data_t expected;
        mem_pkg::data_t actual;
    } err_report_t;

endpackage
